// File: mipsDecode_settings.svh
`ifndef MIPS_DECODE_SETTINGS_SVH
`define MIPS_DECODE_SETTINGS_SVH

// Datapath widths
`define WORD_WIDTH      32
`define REG_COUNT       32
`define REG_IDX_WIDTH   5
`define OPCODE_WIDTH    6

// Primary opcodes handled by decode
`define OP_RTYPE        6'd0
`define OP_J            6'd2
`define OP_ADDI         6'd8
`define OP_ANDI         6'd12
`define OP_ORI          6'd13
`define OP_XORI         6'd14
`define OP_LW           6'd35
`define OP_SW           6'd43

// Width of the zero/sign-extended immediate field
`define IMM_WIDTH       16

`endif

// File: mipsDecodePkg.sv
`include "mipsDecode_settings.svh"

package mipsDecodePkg;

    // Plain vectors with a meaning
    typedef logic [`WORD_WIDTH-1:0]    word_t;
    typedef logic [`REG_IDX_WIDTH-1:0] regIdx_t;
    typedef logic [`OPCODE_WIDTH-1:0]  opcode_t;

    // ALU operation requested from execute
    typedef enum logic [2:0]
    {
        aluAdd   = 3'd0,
        aluSub   = 3'd1,
        aluAnd   = 3'd2,
        aluOr    = 3'd3,
        aluXor   = 3'd4,
        aluFunct = 3'd5
    } aluOp_t;

    //////////////////////////////
    // Control groups

    typedef struct packed
    {
        logic regWrite;
        logic memToReg;
    } wbCtrl_t;

    typedef struct packed
    {
        logic memRead;
        logic memWrite;
    } memCtrl_t;

    typedef struct packed
    {
        logic   regDst;
        logic   aluSrc;
        aluOp_t aluOp;
    } exeCtrl_t;

    // All zeros is a bubble
    typedef struct packed
    {
        wbCtrl_t  wb;
        memCtrl_t mem;
        exeCtrl_t exe;
    } ctrlBundle_t;

    //////////////////////////////
    // Pipeline registers

    typedef struct packed
    {
        ctrlBundle_t ctrl;
        word_t       pc;
        word_t       regA;
        word_t       regB;
        word_t       immediate;
        regIdx_t     rs;
        regIdx_t     rt;
        regIdx_t     rd;
        opcode_t     opcode;
    } idExReg_t;

    typedef struct packed
    {
        word_t pc;
        word_t instr;
    } ifIdReg_t;

endpackage

// File: controlBlock.sv
`timescale 1ns/1ps
`include "mipsDecode_settings.svh"

module controlBlock
    import mipsDecodePkg::*;
(
    input  opcode_t     opcode,
    output ctrlBundle_t ctrl,
    output logic        zeroExtend,
    output logic        isJump
);

    //////////////////////////////
    // Opcode table

    always_comb
    begin
        // Unknown opcodes fall through as a bubble
        ctrl       = '0;
        zeroExtend = 1'b0;
        isJump     = 1'b0;

        case (opcode)
            `OP_RTYPE:
            begin
                ctrl.wb.regWrite = 1'b1;
                ctrl.exe.regDst  = 1'b1;
                ctrl.exe.aluOp   = aluFunct;
            end
            `OP_LW:
            begin
                ctrl.wb.regWrite = 1'b1;
                ctrl.wb.memToReg = 1'b1;
                ctrl.mem.memRead = 1'b1;
                ctrl.exe.aluSrc  = 1'b1;
                ctrl.exe.aluOp   = aluAdd;
            end
            `OP_SW:
            begin
                ctrl.mem.memWrite = 1'b1;
                ctrl.exe.aluSrc   = 1'b1;
                ctrl.exe.aluOp    = aluAdd;
            end
            `OP_ADDI:
            begin
                ctrl.wb.regWrite = 1'b1;
                ctrl.exe.aluSrc  = 1'b1;
                ctrl.exe.aluOp   = aluAdd;
            end
            // Logical immediates are zero-extended
            `OP_ANDI:
            begin
                ctrl.wb.regWrite = 1'b1;
                ctrl.exe.aluSrc  = 1'b1;
                ctrl.exe.aluOp   = aluAnd;
                zeroExtend       = 1'b1;
            end
            `OP_ORI:
            begin
                ctrl.wb.regWrite = 1'b1;
                ctrl.exe.aluSrc  = 1'b1;
                ctrl.exe.aluOp   = aluOr;
                zeroExtend       = 1'b1;
            end
            `OP_XORI:
            begin
                ctrl.wb.regWrite = 1'b1;
                ctrl.exe.aluSrc  = 1'b1;
                ctrl.exe.aluOp   = aluXor;
                zeroExtend       = 1'b1;
            end
            // Jump resolves in decode, nothing goes down the pipe
            `OP_J:
                isJump = 1'b1;
            default:
                ctrl = '0;
        endcase
    end

endmodule

// File: hazardDetectionUnit.sv
`timescale 1ns/1ps

module hazardDetectionUnit
    import mipsDecodePkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    exeMemRead,
    input  regIdx_t exeRd,
    input  regIdx_t rs,
    input  regIdx_t rt,
    output logic    stall,
    output logic    pcWrite,
    output logic    ifIdWrite
);

    logic rdMatch;

    // Load in execute targets a source of the instruction in decode
    assign rdMatch = (exeRd == rs) || (exeRd == rt);

    // r0 never carries a dependency
    assign stall = exeMemRead && (exeRd != '0) && rdMatch;

    // PC and IF/ID hold together
    assign pcWrite   = !stall;
    assign ifIdWrite = !stall;

    //////////////////////////////
    // Checks

    // Only a load in execute may hold the front end
    assert property (@(posedge clk) disable iff (rst) !pcWrite |-> exeMemRead)
        else $error("stall without a load in execute");

endmodule

// File: registerFile.sv
`timescale 1ns/1ps
`include "mipsDecode_settings.svh"

module registerFile
    import mipsDecodePkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    write,
    input  logic    debugOn,
    input  regIdx_t writeAddr,
    input  word_t   writeData,
    input  regIdx_t readAddrA,
    input  regIdx_t readAddrB,
    input  regIdx_t debugAddr,
    output word_t   readA,
    output word_t   readB,
    output word_t   debugData
);

    word_t regs [`REG_COUNT];
    logic  writeEn;

    // Debug blocks writeback, r0 is hardwired
    assign writeEn = write && !debugOn && (writeAddr != '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (writeEn)
        begin
            regs[writeAddr] <= writeData;
        end
    end

    // Same-cycle write is forwarded to the reader
    function automatic word_t readPort(input regIdx_t addr);
        word_t value;
        if (addr == '0)
            value = '0;
        else if (writeEn && (addr == writeAddr))
            value = writeData;
        else
            value = regs[addr];
        return value;
    endfunction

    always_comb
    begin
        readA     = readPort(readAddrA);
        readB     = readPort(readAddrB);
        debugData = readPort(debugAddr);
    end

    // r0 storage never picks up a value
    assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
        else $error("register 0 is not zero");

endmodule

// File: ifIdRegister.sv
`timescale 1ns/1ps

module ifIdRegister
    import mipsDecodePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  ifIdReg_t fetchIn,
    input  logic     fetchValid,
    input  logic     write,
    input  logic     flush,
    input  logic     freeze,
    output ifIdReg_t ifId
);

    // All-zero instruction word is sll r0,r0,0
    localparam ifIdReg_t nopEntry = '0;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ifId <= nopEntry;
        end
        else if (freeze)
        begin
            // Debug freeze wins over everything
            ifId <= ifId;
        end
        else if (flush)
        begin
            ifId <= nopEntry;
        end
        else if (write)
        begin
            if (fetchValid)
                ifId <= fetchIn;
            else
                ifId <= nopEntry;
        end
        // write low on a stall, contents held
    end

endmodule

// File: instructionDecode.sv
`timescale 1ns/1ps

module instructionDecode
    import mipsDecodePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  ifIdReg_t ifId,
    input  logic     wbWrite,
    input  regIdx_t  wbReg,
    input  word_t    wbData,
    input  logic     exeMemRead,
    input  regIdx_t  exeRd,
    input  logic     idFlush,
    input  logic     debugOn,
    input  regIdx_t  debugReg,
    input  logic     stopDebug,
    output idExReg_t idEx,
    output logic     pcWrite,
    output logic     ifIdWrite,
    output logic     jumpTaken,
    output word_t    jumpTarget,
    output word_t    debugData
);

    opcode_t     opcode;
    regIdx_t     rs;
    regIdx_t     rt;
    regIdx_t     rd;
    logic [15:0] imm16;
    logic [25:0] jumpIndex;
    ctrlBundle_t ctrl;
    logic        zeroExtend;
    logic        isJump;
    logic        stall;
    word_t       regA;
    word_t       regB;
    word_t       immediate;

    //////////////////////////////
    // Instruction fields

    assign opcode    = ifId.instr[31:26];
    assign rs        = ifId.instr[25:21];
    assign rt        = ifId.instr[20:16];
    assign rd        = ifId.instr[15:11];
    assign imm16     = ifId.instr[15:0];
    assign jumpIndex = ifId.instr[25:0];

    controlBlock controlUnit (
        .opcode     (opcode),
        .ctrl       (ctrl),
        .zeroExtend (zeroExtend),
        .isJump     (isJump)
    );

    hazardDetectionUnit hazardUnit (
        .clk        (clk),
        .rst        (rst),
        .exeMemRead (exeMemRead),
        .exeRd      (exeRd),
        .rs         (rs),
        .rt         (rt),
        .stall      (stall),
        .pcWrite    (pcWrite),
        .ifIdWrite  (ifIdWrite)
    );

    registerFile regFile (
        .clk       (clk),
        .rst       (rst),
        .write     (wbWrite),
        .debugOn   (debugOn),
        .writeAddr (wbReg),
        .writeData (wbData),
        .readAddrA (rs),
        .readAddrB (rt),
        .debugAddr (debugReg),
        .readA     (regA),
        .readB     (regB),
        .debugData (debugData)
    );

    // Logical ops take the raw 16 bits
    assign immediate = zeroExtend ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};

    // Pseudo-direct jump target, pc passes through otherwise
    assign jumpTaken  = isJump;
    assign jumpTarget = isJump ? {ifId.pc[31:28], jumpIndex, 2'b00} : ifId.pc;

    //////////////////////////////
    // ID/EX register

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            idEx <= '0;
        end
        else if (!stopDebug)
        begin
            // Stall and flush both insert a bubble
            idEx.ctrl      <= (stall || idFlush) ? '0 : ctrl;
            idEx.pc        <= ifId.pc;
            idEx.regA      <= regA;
            idEx.regB      <= regB;
            idEx.immediate <= immediate;
            idEx.rs        <= rs;
            idEx.rt        <= rt;
            idEx.rd        <= rd;
            idEx.opcode    <= opcode;
        end
    end

    // Bubble request must reach execute as empty control
    assert property (@(posedge clk) disable iff (rst)
        (stall || idFlush) && !stopDebug |=> idEx.ctrl == '0)
        else $error("bubble captured with live control");

endmodule

// File: decodeSubsystem.sv
`timescale 1ns/1ps

module decodeSubsystem
    import mipsDecodePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  ifIdReg_t fetchIn,
    input  logic     fetchValid,
    input  logic     wbWrite,
    input  regIdx_t  wbReg,
    input  word_t    wbData,
    input  logic     exeMemRead,
    input  regIdx_t  exeRd,
    input  logic     idFlush,
    input  logic     debugOn,
    input  regIdx_t  debugReg,
    input  logic     stopDebug,
    output idExReg_t idEx,
    output logic     pcWrite,
    output logic     jumpTaken,
    output word_t    jumpTarget,
    output word_t    debugData
);

    ifIdReg_t ifId;
    logic     ifIdWrite;

    // Front end register, frozen together with ID/EX under debug
    ifIdRegister ifIdStage (
        .clk        (clk),
        .rst        (rst),
        .fetchIn    (fetchIn),
        .fetchValid (fetchValid),
        .write      (ifIdWrite),
        .flush      (idFlush),
        .freeze     (stopDebug),
        .ifId       (ifId)
    );

    instructionDecode decodeStage (
        .clk        (clk),
        .rst        (rst),
        .ifId       (ifId),
        .wbWrite    (wbWrite),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .exeMemRead (exeMemRead),
        .exeRd      (exeRd),
        .idFlush    (idFlush),
        .debugOn    (debugOn),
        .debugReg   (debugReg),
        .stopDebug  (stopDebug),
        .idEx       (idEx),
        .pcWrite    (pcWrite),
        .ifIdWrite  (ifIdWrite),
        .jumpTaken  (jumpTaken),
        .jumpTarget (jumpTarget),
        .debugData  (debugData)
    );

endmodule

// File: tb_decodeSubsystem.sv
`timescale 1ns/1ps
`include "mipsDecode_settings.svh"

module tb_decodeSubsystem
    import mipsDecodePkg::*;
();

    typedef struct
    {
        string    name;
        ifIdReg_t fetchIn;
        logic     fetchValid;
        logic     wbWrite;
        regIdx_t  wbReg;
        word_t    wbData;
        logic     exeMemRead;
        regIdx_t  exeRd;
        logic     idFlush;
        logic     debugOn;
        regIdx_t  debugReg;
        logic     stopDebug;
        // idEx seen at this row's falling edge, before its inputs apply
        idExReg_t expIdEx;
        logic     expPcWrite;
        logic     expJumpTaken;
        word_t    expJumpTarget;
        word_t    expDebugData;
    } stimRow_t;

    localparam word_t pcBase = 32'hA040_0000;

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    ifIdReg_t fetchIn = '0;
    logic     fetchValid = 1'b0;
    logic     wbWrite = 1'b0;
    regIdx_t  wbReg = '0;
    word_t    wbData = '0;
    logic     exeMemRead = 1'b0;
    regIdx_t  exeRd = '0;
    logic     idFlush = 1'b0;
    logic     debugOn = 1'b0;
    regIdx_t  debugReg = '0;
    logic     stopDebug = 1'b0;
    idExReg_t idEx;
    logic     pcWrite;
    logic     jumpTaken;
    word_t    jumpTarget;
    word_t    debugData;

    stimRow_t rows [$];
    integer   seed = 32'hc844;
    int       cycleCount = 0;
    int       cycleLimit = 0;

    // Golden model state
    word_t    mRegs [`REG_COUNT];
    ifIdReg_t mIfId;
    idExReg_t mIdEx;
    idExReg_t finalIdEx;

    decodeSubsystem u_dut (
        .clk        (clk),
        .rst        (rst),
        .fetchIn    (fetchIn),
        .fetchValid (fetchValid),
        .wbWrite    (wbWrite),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .exeMemRead (exeMemRead),
        .exeRd      (exeRd),
        .idFlush    (idFlush),
        .debugOn    (debugOn),
        .debugReg   (debugReg),
        .stopDebug  (stopDebug),
        .idEx       (idEx),
        .pcWrite    (pcWrite),
        .jumpTaken  (jumpTaken),
        .jumpTarget (jumpTarget),
        .debugData  (debugData)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit)
        begin
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout, run did not finish within %0d cycles", cycleLimit);
        end
    end

    //////////////////////////////
    // Instruction encoders

    function automatic word_t rType(input regIdx_t rs, input regIdx_t rt, input regIdx_t rd);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, 6'h20};
    endfunction

    function automatic word_t iType(input opcode_t op, input regIdx_t rs, input regIdx_t rt,
                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jType(input logic [25:0] index);
        return {`OP_J, index};
    endfunction

    task automatic addRow(input string name, input word_t instr, input logic wbW,
                          input regIdx_t wbR, input logic memRd, input regIdx_t rdExe,
                          input logic flush, input logic dbgOn, input regIdx_t dbgReg,
                          input logic stop);
        stimRow_t r;
        r.name       = name;
        r.fetchIn.pc = pcBase + 32'(4 * rows.size());
        r.fetchIn.instr = instr;
        r.fetchValid = 1'b1;
        r.wbWrite    = wbW;
        r.wbReg      = wbR;
        r.wbData     = $random(seed);
        r.exeMemRead = memRd;
        r.exeRd      = rdExe;
        r.idFlush    = flush;
        r.debugOn    = dbgOn;
        r.debugReg   = dbgReg;
        r.stopDebug  = stop;
        rows.push_back(r);
    endtask

    //////////////////////////////
    // Golden model

    // Control groups per opcode, unknown and j give a bubble
    function automatic ctrlBundle_t expectedCtrl(input opcode_t op);
        ctrlBundle_t c;
        c = '0;
        case (op)
            `OP_RTYPE: c = '{wb: 2'b10, mem: 2'b00, exe: '{1'b1, 1'b0, aluFunct}};
            `OP_LW:    c = '{wb: 2'b11, mem: 2'b10, exe: '{1'b0, 1'b1, aluAdd}};
            `OP_SW:    c = '{wb: 2'b00, mem: 2'b01, exe: '{1'b0, 1'b1, aluAdd}};
            `OP_ADDI:  c = '{wb: 2'b10, mem: 2'b00, exe: '{1'b0, 1'b1, aluAdd}};
            `OP_ANDI:  c = '{wb: 2'b10, mem: 2'b00, exe: '{1'b0, 1'b1, aluAnd}};
            `OP_ORI:   c = '{wb: 2'b10, mem: 2'b00, exe: '{1'b0, 1'b1, aluOr}};
            `OP_XORI:  c = '{wb: 2'b10, mem: 2'b00, exe: '{1'b0, 1'b1, aluXor}};
            default:   c = '0;
        endcase
        return c;
    endfunction

    // Register read seen during a row, new data wins on a matching write
    function automatic word_t modelRead(input regIdx_t addr, input stimRow_t r);
        if (addr == 0)
            return '0;
        if (r.wbWrite && !r.debugOn && r.wbReg == addr)
            return r.wbData;
        return mRegs[addr];
    endfunction

    task automatic modelStep(input int k);
        stimRow_t r;
        word_t    instr;
        opcode_t  op;
        logic     stall;
        logic     logicalOp;
        r     = rows[k];
        instr = mIfId.instr;
        op    = instr[31:26];
        stall = r.exeMemRead && r.exeRd != 0
                && (r.exeRd == instr[25:21] || r.exeRd == instr[20:16]);
        logicalOp = (op == `OP_ANDI) || (op == `OP_ORI) || (op == `OP_XORI);

        r.expIdEx       = mIdEx;
        r.expPcWrite    = !stall;
        r.expJumpTaken  = (op == `OP_J);
        r.expJumpTarget = (op == `OP_J) ? {mIfId.pc[31:28], instr[25:0], 2'b00} : mIfId.pc;
        r.expDebugData  = modelRead(r.debugReg, r);

        if (!r.stopDebug)
        begin
            mIdEx.ctrl      = (stall || r.idFlush) ? '0 : expectedCtrl(op);
            mIdEx.pc        = mIfId.pc;
            mIdEx.regA      = modelRead(instr[25:21], r);
            mIdEx.regB      = modelRead(instr[20:16], r);
            mIdEx.immediate = logicalOp ? {16'h0, instr[15:0]} : 32'(signed'(instr[15:0]));
            mIdEx.rs        = instr[25:21];
            mIdEx.rt        = instr[20:16];
            mIdEx.rd        = instr[15:11];
            mIdEx.opcode    = op;
            if (r.idFlush)
                mIfId = '0;
            else if (!stall)
                mIfId = r.fetchValid ? r.fetchIn : '0;
        end
        if (r.wbWrite && !r.debugOn && r.wbReg != 0)
            mRegs[r.wbReg] = r.wbData;
        rows[k] = r;
    endtask

    //////////////////////////////
    // Drive and check

    task automatic checkValue(input string testName, input string field,
                              input logic [$bits(idExReg_t)-1:0] expected,
                              input logic [$bits(idExReg_t)-1:0] actual);
        assert (actual === expected)
        else
        begin
            $display("mismatch %s %s: expected %h actual %h", testName, field, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic applyRow(input stimRow_t r);
        fetchIn    = r.fetchIn;
        fetchValid = r.fetchValid;
        wbWrite    = r.wbWrite;
        wbReg      = r.wbReg;
        wbData     = r.wbData;
        exeMemRead = r.exeMemRead;
        exeRd      = r.exeRd;
        idFlush    = r.idFlush;
        debugOn    = r.debugOn;
        debugReg   = r.debugReg;
        stopDebug  = r.stopDebug;
    endtask

    initial
    begin
        // name, fetch, wbWrite, wbReg, exeMemRead, exeRd, flush, debugOn, debugReg, stop
        addRow("write r1", 32'h0, 1, 1, 0, 0, 0, 0, 0, 0);
        addRow("write r2", rType(1, 2, 3), 1, 2, 0, 0, 0, 0, 0, 0);
        addRow("write r0 ignored", rType(0, 2, 4), 1, 0, 0, 0, 0, 0, 0, 0);
        addRow("r0 reads zero", rType(5, 1, 6), 0, 0, 0, 0, 0, 0, 1, 0);
        addRow("write-through r5", iType(`OP_LW, 1, 7, 16'hFFF0), 1, 5, 0, 0, 0, 0, 5, 0);
        addRow("lw decode", iType(`OP_SW, 2, 5, 16'h8004), 0, 0, 0, 0, 0, 0, 2, 0);
        addRow("sw decode", iType(`OP_ADDI, 1, 8, 16'hFFFF), 0, 0, 0, 0, 0, 0, 0, 0);
        addRow("addi decode", iType(`OP_ANDI, 2, 9, 16'hF00F), 0, 0, 0, 0, 0, 0, 0, 0);
        addRow("andi decode", iType(`OP_ORI, 5, 10, 16'h8000), 0, 0, 0, 0, 0, 0, 0, 0);
        addRow("ori decode", iType(`OP_XORI, 1, 11, 16'hABCD), 0, 0, 0, 0, 0, 0, 0, 0);
        addRow("xori decode", jType(26'h3ABCDE), 0, 0, 0, 0, 0, 0, 0, 0);
        addRow("jump decode", rType(7, 2, 10), 0, 0, 0, 0, 0, 0, 0, 0);
        addRow("load-use on rs", iType(`OP_ADDI, 3, 3, 16'h0010), 0, 0, 1, 7, 0, 0, 0, 0);
        addRow("stall released", rType(0, 0, 11), 0, 0, 0, 0, 0, 0, 0, 0);
        addRow("r0 load no stall", rType(3, 2, 12), 0, 0, 1, 0, 0, 0, 0, 0);
        addRow("load-use on rt", iType(`OP_ORI, 1, 1, 16'h0001), 0, 0, 1, 2, 0, 0, 0, 0);
        addRow("flush", rType(1, 2, 13), 0, 0, 0, 0, 1, 0, 0, 0);
        addRow("nop after flush", rType(2, 1, 14), 0, 0, 0, 0, 0, 0, 0, 0);
        addRow("debug blocks write", rType(1, 2, 15), 1, 1, 0, 0, 0, 1, 1, 0);
        addRow("debug read r2", iType(`OP_XORI, 2, 2, 16'h00FF), 1, 2, 0, 0, 0, 1, 2, 0);
        addRow("freeze", iType(`OP_LW, 1, 1, 16'h0004), 0, 0, 0, 0, 0, 1, 5, 1);
        addRow("freeze holds", jType(26'h1), 0, 0, 0, 0, 0, 1, 8, 1);
        addRow("release", rType(5, 8, 16), 0, 0, 0, 0, 0, 0, 0, 0);
        addRow("drain", 32'h0, 0, 0, 0, 0, 0, 0, 0, 0);
        addRow("drain 2", 32'h0, 0, 0, 0, 0, 0, 0, 0, 0);

        // State right after reset
        for (int i = 0; i < `REG_COUNT; i++)
            mRegs[i] = '0;
        mIfId = '0;
        mIdEx = '0;
        for (int k = 0; k < rows.size(); k++)
            modelStep(k);
        finalIdEx  = mIdEx;
        cycleLimit = rows.size() + 10 + 20;

        repeat (10) @(posedge clk);

        for (int k = 0; k < rows.size(); k++)
        begin
            @(negedge clk);
            rst = 1'b0;
            checkValue(rows[k].name, "idEx", rows[k].expIdEx, idEx);
            applyRow(rows[k]);
            #1;
            checkValue(rows[k].name, "pcWrite", rows[k].expPcWrite, pcWrite);
            checkValue(rows[k].name, "jumpTaken", rows[k].expJumpTaken, jumpTaken);
            checkValue(rows[k].name, "jumpTarget", rows[k].expJumpTarget, jumpTarget);
            checkValue(rows[k].name, "debugData", rows[k].expDebugData, debugData);
        end

        // Last row's decode lands one edge later
        @(negedge clk);
        checkValue("final", "idEx", finalIdEx, idEx);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: files.f
+incdir+.
mipsDecodePkg.sv
controlBlock.sv
hazardDetectionUnit.sv
registerFile.sv
ifIdRegister.sv
instructionDecode.sv
decodeSubsystem.sv
tb_decodeSubsystem.sv

// File: Bender.yml
package:
  name: mips_decode

sources:
  - include_dirs:
      - .
    files:
      - mipsDecodePkg.sv
      - controlBlock.sv
      - hazardDetectionUnit.sv
      - registerFile.sv
      - ifIdRegister.sv
      - instructionDecode.sv
      - decodeSubsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_decodeSubsystem.sv
